// File: logic/bus_map_pkg.sv
`default_nettype none

package bus_map_pkg;

   localparam int addr_w = 12;
   localparam int data_w = 32;

   typedef logic [addr_w-1:0] bus_addr_t;
   typedef logic [data_w-1:0] bus_word_t;

   // engine memory offset and configuration index widths
   localparam int eng_addr_w = 8;
   localparam int conf_reg_addr_w = 4;

   // region bases
   localparam bus_addr_t eng_base = 12'h800;
   localparam bus_addr_t conf_base = 12'h100;
   localparam bus_addr_t scratch_base = 12'h110;
   localparam bus_addr_t alias_addr = 12'h000;

   // masks keep the block bits, drop the in-block offset
   localparam bus_addr_t reg_blk_mask =
      bus_addr_t'({{(addr_w - conf_reg_addr_w){1'b1}}, {conf_reg_addr_w{1'b0}}});
   localparam bus_addr_t eng_blk_mask =
      bus_addr_t'({{(addr_w - eng_addr_w){1'b1}}, {eng_addr_w{1'b0}}});

endpackage

`default_nettype wire

// File: logic/engine_pkg.sv
`default_nettype none

package engine_pkg;

   typedef logic [bus_map_pkg::conf_reg_addr_w-1:0] conf_idx_t;

   // configuration register indices
   localparam conf_idx_t reg_ctrl = 4'd0;
   localparam conf_idx_t reg_src = 4'd1;
   localparam conf_idx_t reg_dst = 4'd2;
   localparam conf_idx_t reg_len = 4'd3;
   localparam conf_idx_t reg_op = 4'd4;
   localparam conf_idx_t reg_const = 4'd5;

   typedef logic [bus_map_pkg::eng_addr_w-1:0] eng_off_t;

   // 0 to 256 elements
   typedef logic [bus_map_pkg::eng_addr_w:0] run_len_t;
   localparam run_len_t max_len = 9'd256;

   typedef enum logic [1:0] {
      op_copy = 2'd0,
      op_add_const = 2'd1,
      op_accum = 2'd2
   } eng_op_t;

   typedef enum logic [2:0] {
      st_idle,
      st_fill,
      st_stream,
      st_flush,
      st_done
   } ctrl_state_t;

endpackage

`default_nettype wire

// File: logic/addr_decoder.sv
`timescale 1ns/10ps
`default_nettype none

module addr_decoder (
   input  wire logic                   clk,
   input  wire logic                   rst,
   input  wire logic                   ctr_req,
   input  wire logic                   ctr_rnw,
   input  wire bus_map_pkg::bus_addr_t ctr_addr,
   input  wire bus_map_pkg::bus_word_t data_to_wr,
   input  wire bus_map_pkg::bus_word_t eng_data_to_rd,
   output logic                        eng_req,
   output logic                        conf_req,
   output bus_map_pkg::bus_word_t      data_to_rd
);

   logic hit_scratch;
   logic hit_conf;
   logic hit_eng;
   logic hit_alias;
   logic scratch_we;
   bus_map_pkg::bus_word_t scratch_reg;

   // priority: scratch, configuration, engine, then the alias at zero
   always_comb begin
      hit_scratch = 1'b0;
      hit_conf = 1'b0;
      hit_eng = 1'b0;
      hit_alias = 1'b0;
      if ((ctr_addr & bus_map_pkg::reg_blk_mask) == bus_map_pkg::scratch_base) begin
         hit_scratch = 1'b1;
      end else if ((ctr_addr & bus_map_pkg::reg_blk_mask) == bus_map_pkg::conf_base) begin
         hit_conf = 1'b1;
      end else if ((ctr_addr & bus_map_pkg::eng_blk_mask) == bus_map_pkg::eng_base) begin
         hit_eng = 1'b1;
      end else if (ctr_addr == bus_map_pkg::alias_addr) begin
         hit_alias = 1'b1;
      end
   end

   assign conf_req = ctr_req & (hit_conf | hit_alias);
   assign eng_req = ctr_req & hit_eng;
   assign scratch_we = ctr_req & ~ctr_rnw & hit_scratch;

   always_ff @(posedge clk) begin
      if (rst) begin
         scratch_reg <= '0;
      end else if (scratch_we) begin
         scratch_reg <= data_to_wr;
      end
   end

   // configuration is write only, reads as zero
   always_comb begin
      data_to_rd = '0;
      if (hit_scratch) begin
         data_to_rd = scratch_reg;
      end else if (hit_eng) begin
         data_to_rd = eng_data_to_rd;
      end
   end

   a_one_region: assert property (@(posedge clk) disable iff (rst)
      !(eng_req && conf_req));

endmodule

`default_nettype wire

// File: logic/conf_regs.sv
`timescale 1ns/10ps
`default_nettype none

module conf_regs (
   input  wire logic                   clk,
   input  wire logic                   rst,
   input  wire logic                   conf_req,
   input  wire logic                   ctr_rnw,
   input  wire bus_map_pkg::bus_addr_t ctr_addr,
   input  wire bus_map_pkg::bus_word_t data_to_wr,
   output logic                        start,
   output engine_pkg::eng_off_t        src_off,
   output engine_pkg::eng_off_t        dst_off,
   output engine_pkg::run_len_t        run_len,
   output engine_pkg::eng_op_t         op,
   output bus_map_pkg::bus_word_t      const_val
);

   engine_pkg::conf_idx_t idx;
   logic wr;
   engine_pkg::run_len_t len_clip;
   engine_pkg::eng_op_t op_in;

   assign idx = ctr_addr[bus_map_pkg::conf_reg_addr_w-1:0];
   assign wr = conf_req & ~ctr_rnw;

   assign len_clip = (data_to_wr > bus_map_pkg::bus_word_t'(engine_pkg::max_len)) ?
                     engine_pkg::max_len : data_to_wr[bus_map_pkg::eng_addr_w:0];

   // unknown codes fall back to copy
   always_comb begin
      case (data_to_wr)
         32'd1:   op_in = engine_pkg::op_add_const;
         32'd2:   op_in = engine_pkg::op_accum;
         default: op_in = engine_pkg::op_copy;
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         src_off <= '0;
         dst_off <= '0;
         run_len <= '0;
         op <= engine_pkg::op_copy;
         const_val <= '0;
      end else if (wr) begin
         case (idx)
            engine_pkg::reg_src:   src_off <= data_to_wr[bus_map_pkg::eng_addr_w-1:0];
            engine_pkg::reg_dst:   dst_off <= data_to_wr[bus_map_pkg::eng_addr_w-1:0];
            engine_pkg::reg_len:   run_len <= len_clip;
            engine_pkg::reg_op:    op <= op_in;
            engine_pkg::reg_const: const_val <= data_to_wr;
            default: ;
         endcase
      end
   end

   // ctrl is not stored, bit 0 fires a one-cycle start
   always_ff @(posedge clk) begin
      if (rst) begin
         start <= 1'b0;
      end else begin
         start <= wr && (idx == engine_pkg::reg_ctrl) && data_to_wr[0];
      end
   end

endmodule

`default_nettype wire

// File: logic/eng_mem.sv
`timescale 1ns/10ps
`default_nettype none

module eng_mem (
   input  wire logic                   clk,
   input  wire logic                   eng_req,
   input  wire logic                   ctr_rnw,
   input  wire bus_map_pkg::bus_addr_t ctr_addr,
   input  wire bus_map_pkg::bus_word_t data_to_wr,
   output bus_map_pkg::bus_word_t      eng_data_to_rd,
   input  wire logic                   rd_en,
   input  wire logic                   wr_en,
   input  wire engine_pkg::eng_off_t   rd_addr,
   input  wire engine_pkg::eng_off_t   wr_addr,
   input  wire bus_map_pkg::bus_word_t wr_data,
   output bus_map_pkg::bus_word_t      rd_data
);

   localparam int depth = 2 ** bus_map_pkg::eng_addr_w;

   bus_map_pkg::bus_word_t mem [depth];
   engine_pkg::eng_off_t bus_off;

   assign bus_off = ctr_addr[bus_map_pkg::eng_addr_w-1:0];

   // bus side reads combinationally
   assign eng_data_to_rd = mem[bus_off];

   // engine write is issued last so it wins on a shared word
   always_ff @(posedge clk) begin
      if (eng_req && !ctr_rnw) begin
         mem[bus_off] <= data_to_wr;
      end
      if (wr_en) begin
         mem[wr_addr] <= wr_data;
      end
   end

   // one cycle read latency for the engine
   always_ff @(posedge clk) begin
      if (rd_en) begin
         rd_data <= mem[rd_addr];
      end
   end

endmodule

`default_nettype wire

// File: logic/run_counter.sv
`timescale 1ns/10ps
`default_nettype none

module run_counter (
   input  wire logic                 clk,
   input  wire logic                 rst,
   input  wire logic                 load,
   input  wire logic                 step,
   input  wire engine_pkg::run_len_t run_len,
   output logic                      last,
   output logic                      empty
);

   // elements still to be read
   engine_pkg::run_len_t count;

   always_ff @(posedge clk) begin
      if (rst) begin
         count <= '0;
      end else if (load) begin
         count <= run_len;
      end else if (step) begin
         count <= count - 1'b1;
      end
   end

   assign last = (count == engine_pkg::run_len_t'(1));

   // while loading, look at the incoming length
   assign empty = load ? (run_len == '0) : (count == '0);

   a_no_underflow: assert property (@(posedge clk) disable iff (rst)
      step |-> count != '0);

endmodule

`default_nettype wire

// File: logic/eng_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module eng_ctrl (
   input  wire logic                clk,
   input  wire logic                rst,
   input  wire logic                start,
   input  wire logic                last,
   input  wire logic                empty,
   input  wire engine_pkg::eng_op_t op,
   output logic                     load,
   output logic                     step,
   output logic                     addr_load,
   output logic                     rd_adv,
   output logic                     acc_clear,
   output logic                     acc_en,
   output logic                     rd_en,
   output logic                     wr_en,
   output logic                     busy,
   output logic                     done
);

   engine_pkg::ctrl_state_t state;
   engine_pkg::ctrl_state_t state_nxt;

   always_comb begin
      state_nxt = state;
      case (state)
         engine_pkg::st_idle:
            if (start) begin
               state_nxt = empty ? engine_pkg::st_done : engine_pkg::st_fill;
            end
         engine_pkg::st_fill:
            state_nxt = last ? engine_pkg::st_flush : engine_pkg::st_stream;
         engine_pkg::st_stream:
            if (last) begin
               state_nxt = engine_pkg::st_flush;
            end
         engine_pkg::st_flush:
            state_nxt = engine_pkg::st_done;
         default:
            state_nxt = engine_pkg::st_idle;
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= engine_pkg::st_idle;
         done <= 1'b0;
      end else begin
         state <= state_nxt;
         done <= (state == engine_pkg::st_done);
      end
   end

   // start only counts when idle
   assign load = (state == engine_pkg::st_idle) & start;
   assign addr_load = load;
   assign acc_clear = load;

   // one read per cycle in fill and stream
   assign step = (state == engine_pkg::st_fill) | (state == engine_pkg::st_stream);
   assign rd_adv = step;
   assign rd_en = step;

   // read data is valid one cycle after each read
   assign acc_en = (state == engine_pkg::st_stream) | (state == engine_pkg::st_flush);
   assign wr_en = ((state == engine_pkg::st_stream) && (op != engine_pkg::op_accum)) ||
                  (state == engine_pkg::st_flush);

   assign busy = (state != engine_pkg::st_idle);

   a_wr_in_run: assert property (@(posedge clk) disable iff (rst)
      wr_en |-> $past(state != engine_pkg::st_idle));

endmodule

`default_nettype wire

// File: logic/eng_datapath.sv
`timescale 1ns/10ps
`default_nettype none

module eng_datapath (
   input  wire logic                   clk,
   input  wire logic                   rst,
   input  wire logic                   addr_load,
   input  wire logic                   rd_adv,
   input  wire logic                   acc_clear,
   input  wire logic                   acc_en,
   input  wire engine_pkg::eng_op_t    op,
   input  wire engine_pkg::eng_off_t   src_off,
   input  wire engine_pkg::eng_off_t   dst_off,
   input  wire bus_map_pkg::bus_word_t const_val,
   input  wire bus_map_pkg::bus_word_t rd_data,
   output engine_pkg::eng_off_t        rd_addr,
   output engine_pkg::eng_off_t        wr_addr,
   output bus_map_pkg::bus_word_t      wr_data
);

   logic wr_adv;
   bus_map_pkg::bus_word_t acc;
   bus_map_pkg::bus_word_t add_a;
   bus_map_pkg::bus_word_t sum;

   // write side trails the read side by the memory latency
   always_ff @(posedge clk) begin
      if (rst) begin
         wr_adv <= 1'b0;
      end else begin
         wr_adv <= rd_adv;
      end
   end

   // pointers wrap at 256
   always_ff @(posedge clk) begin
      if (addr_load) begin
         rd_addr <= src_off;
         wr_addr <= dst_off;
      end else begin
         if (rd_adv) begin
            rd_addr <= rd_addr + 1'b1;
         end
         if (wr_adv && op != engine_pkg::op_accum) begin
            wr_addr <= wr_addr + 1'b1;
         end
      end
   end

   // one adder: constant for add, running total for accumulate
   assign add_a = (op == engine_pkg::op_accum) ? acc : const_val;
   assign sum = add_a + rd_data;

   // accumulator starts from the constant so the final sum includes it
   always_ff @(posedge clk) begin
      if (acc_clear) begin
         acc <= const_val;
      end else if (acc_en) begin
         acc <= sum;
      end
   end

   assign wr_data = (op == engine_pkg::op_copy) ? rd_data : sum;

endmodule

`default_nettype wire

// File: logic/engine_sys.sv
`timescale 1ns/10ps
`default_nettype none

module engine_sys (
   input  wire logic                   clk,
   input  wire logic                   rst,
   input  wire logic                   ctr_req,
   input  wire logic                   ctr_rnw,
   input  wire bus_map_pkg::bus_addr_t ctr_addr,
   input  wire bus_map_pkg::bus_word_t data_to_wr,
   output bus_map_pkg::bus_word_t      data_to_rd,
   output logic                        busy,
   output logic                        done
);

   logic eng_req;
   logic conf_req;
   bus_map_pkg::bus_word_t eng_data_to_rd;

   logic start;
   engine_pkg::eng_off_t src_off;
   engine_pkg::eng_off_t dst_off;
   engine_pkg::run_len_t run_len;
   engine_pkg::eng_op_t op;
   bus_map_pkg::bus_word_t const_val;

   logic load;
   logic step;
   logic last;
   logic empty;
   logic addr_load;
   logic rd_adv;
   logic acc_clear;
   logic acc_en;
   logic rd_en;
   logic wr_en;
   engine_pkg::eng_off_t rd_addr;
   engine_pkg::eng_off_t wr_addr;
   bus_map_pkg::bus_word_t wr_data;
   bus_map_pkg::bus_word_t rd_data;

   addr_decoder u_addr_decoder (
      .clk(clk), .rst(rst), .ctr_req(ctr_req), .ctr_rnw(ctr_rnw),
      .ctr_addr(ctr_addr), .data_to_wr(data_to_wr), .eng_data_to_rd(eng_data_to_rd),
      .eng_req(eng_req), .conf_req(conf_req), .data_to_rd(data_to_rd)
   );

   conf_regs u_conf_regs (
      .clk(clk), .rst(rst), .conf_req(conf_req), .ctr_rnw(ctr_rnw),
      .ctr_addr(ctr_addr), .data_to_wr(data_to_wr), .start(start),
      .src_off(src_off), .dst_off(dst_off), .run_len(run_len), .op(op),
      .const_val(const_val)
   );

   eng_mem u_eng_mem (
      .clk(clk), .eng_req(eng_req), .ctr_rnw(ctr_rnw), .ctr_addr(ctr_addr),
      .data_to_wr(data_to_wr), .eng_data_to_rd(eng_data_to_rd), .rd_en(rd_en),
      .wr_en(wr_en), .rd_addr(rd_addr), .wr_addr(wr_addr), .wr_data(wr_data),
      .rd_data(rd_data)
   );

   run_counter u_run_counter (
      .clk(clk), .rst(rst), .load(load), .step(step), .run_len(run_len),
      .last(last), .empty(empty)
   );

   eng_ctrl u_eng_ctrl (
      .clk(clk), .rst(rst), .start(start), .last(last), .empty(empty), .op(op),
      .load(load), .step(step), .addr_load(addr_load), .rd_adv(rd_adv),
      .acc_clear(acc_clear), .acc_en(acc_en), .rd_en(rd_en), .wr_en(wr_en),
      .busy(busy), .done(done)
   );

   eng_datapath u_eng_datapath (
      .clk(clk), .rst(rst), .addr_load(addr_load), .rd_adv(rd_adv),
      .acc_clear(acc_clear), .acc_en(acc_en), .op(op), .src_off(src_off),
      .dst_off(dst_off), .const_val(const_val), .rd_data(rd_data),
      .rd_addr(rd_addr), .wr_addr(wr_addr), .wr_data(wr_data)
   );

endmodule

`default_nettype wire

// File: verification/tb_engine_sys.sv
`timescale 1ns/10ps
`default_nettype none

module tb_engine_sys;

   // memory test touches every word about four times, runs stay under 1000
   localparam int mem_test_cycles = 4 * (256 + 16);
   localparam int run_test_cycles = 1000;
   localparam int max_cycles = 2 * (mem_test_cycles + run_test_cycles);
   localparam int done_wait_limit = 400;

   logic clk;
   logic rst;
   logic ctr_req;
   logic ctr_rnw;
   bus_map_pkg::bus_addr_t ctr_addr;
   bus_map_pkg::bus_word_t data_to_wr;
   bus_map_pkg::bus_word_t data_to_rd;
   logic busy;
   logic done;

   logic [31:0] ref_mem [256];
   logic [31:0] ref_scratch;
   logic [31:0] lfsr;
   int cycles;
   int errors;
   int errors_at_start;
   int tests_run;
   int tests_failed;

   engine_sys u_dut (
      .clk(clk), .rst(rst), .ctr_req(ctr_req), .ctr_rnw(ctr_rnw),
      .ctr_addr(ctr_addr), .data_to_wr(data_to_wr), .data_to_rd(data_to_rd),
      .busy(busy), .done(done)
   );

   always #20 clk = ~clk;

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= max_cycles) begin
         $display("simulation ran past %0d cycles and was stopped", max_cycles);
         $display("Result: FAILED");
         $finish;
      end
   end

   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      lfsr_next = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
   endfunction

   // one lfsr step per bit
   task automatic rand_bits(input int n, output logic [31:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_next(lfsr);
         v = {v[30:0], lfsr[0]};
      end
   endtask

   task automatic bus_write(input logic [11:0] addr, input logic [31:0] data);
      @(posedge clk);
      ctr_req <= 1'b1;
      ctr_rnw <= 1'b0;
      ctr_addr <= addr;
      data_to_wr <= data;
      @(posedge clk);
      ctr_req <= 1'b0;
      ctr_rnw <= 1'b1;
      // scratch block 0x110..0x11f, engine memory 0x800..0x8ff
      if (addr[11:4] == 8'h11) begin
         ref_scratch = data;
      end else if (addr[11:8] == 4'h8) begin
         ref_mem[addr[7:0]] = data;
      end
   endtask

   task automatic bus_read(input logic [11:0] addr, output logic [31:0] data);
      @(posedge clk);
      ctr_req <= 1'b1;
      ctr_rnw <= 1'b1;
      ctr_addr <= addr;
      @(negedge clk);
      data = data_to_rd;
      @(posedge clk);
      ctr_req <= 1'b0;
   endtask

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      assert (got === exp) else begin
         $display("ERROR: %s expected 0x%h got 0x%h", name, exp, got);
         errors++;
      end
   endtask

   task automatic read_check(input logic [11:0] addr, input logic [31:0] exp,
                             input string name);
      logic [31:0] got;
      bus_read(addr, got);
      check_value(name, got, exp);
   endtask

   task automatic check_range(input logic [7:0] first, input int count);
      logic [7:0] off;
      for (int i = 0; i < count; i++) begin
         off = first + 8'(i);
         read_check({4'h8, off}, ref_mem[off], $sformatf("mem[%02h]", off));
      end
   endtask

   task automatic begin_test();
      errors_at_start = errors;
      tests_run++;
   endtask

   task automatic end_test(input string name);
      if (errors == errors_at_start) begin
         $display("test %s: ok", name);
      end else begin
         $display("test %s: %0d errors", name, errors - errors_at_start);
         tests_failed++;
      end
   endtask

   task automatic configure(input int op, input logic [7:0] src, input logic [7:0] dst,
                            input int len, input logic [31:0] cval);
      bus_write(12'h101, 32'(src));
      bus_write(12'h102, 32'(dst));
      bus_write(12'h103, 32'(len));
      bus_write(12'h104, 32'(op));
      bus_write(12'h105, cval);
   endtask

   task automatic wait_busy_rise();
      int n;
      n = 0;
      do begin
         @(negedge clk);
         n++;
      end while (!busy && n < 4);
      assert (busy) else begin
         $display("busy did not rise after start");
         errors++;
      end
   endtask

   // done after L+2 cycles of busy, or after one cycle for an empty run
   task automatic start_and_wait(input logic [11:0] ctrl_addr, input int len);
      int n;
      logic busy_gap;
      bus_write(ctrl_addr, 32'h1);
      wait_busy_rise();
      if (busy) begin
         n = 0;
         busy_gap = 1'b0;
         do begin
            @(negedge clk);
            n++;
            if (!done && !busy) begin
               busy_gap = 1'b1;
            end
         end while (!done && n < done_wait_limit);
         assert (done) else begin
            $display("timed out waiting for done");
            errors++;
         end
         assert (!busy_gap) else begin
            $display("busy fell before done was seen");
            errors++;
         end
         check_value("done latency", n, (len == 0) ? 1 : len + 2);
         check_value("busy at done", busy, 0);
      end
   endtask

   task automatic apply_run(input int op, input logic [7:0] src, input logic [7:0] dst,
                            input int len, input logic [31:0] cval);
      logic [31:0] acc;
      logic [7:0] s;
      logic [7:0] d;
      acc = cval;
      for (int i = 0; i < len; i++) begin
         s = src + 8'(i);
         d = dst + 8'(i);
         if (op == 2) begin
            acc = acc + ref_mem[s];
         end else if (op == 1) begin
            ref_mem[d] = ref_mem[s] + cval;
         end else begin
            ref_mem[d] = ref_mem[s];
         end
      end
      if (op == 2 && len > 0) begin
         ref_mem[dst] = acc;
      end
   endtask

   task automatic run_engine(input int op, input logic [7:0] src, input logic [7:0] dst,
                             input int len, input logic [31:0] cval,
                             input logic [11:0] ctrl_addr);
      configure(op, src, dst, len, cval);
      start_and_wait(ctrl_addr, len);
      apply_run(op, src, dst, len, cval);
   endtask

   task automatic test_reset();
      begin_test();
      @(negedge clk);
      check_value("busy", busy, 0);
      check_value("done", done, 0);
      read_check(12'h110, 32'h0, "scratch");
      read_check(12'h100, 32'h0, "conf read");
      read_check(12'h105, 32'h0, "conf read");
      read_check(12'h200, 32'h0, "unmapped read");
      end_test("reset and decoding");
   endtask

   task automatic test_scratch();
      logic [31:0] w;
      begin_test();
      repeat (4) begin
         rand_bits(32, w);
         bus_write(12'h110, w);
         read_check(12'h110, ref_scratch, "scratch");
         read_check(12'h115, ref_scratch, "scratch at 0x115");
      end
      read_check(12'h100, 32'h0, "conf base");
      read_check(12'h000, 32'h0, "ctrl alias");
      // a stored configuration value still reads as zero
      bus_write(12'h105, ref_scratch);
      read_check(12'h105, 32'h0, "conf const");
      end_test("scratch register");
   endtask

   task automatic test_mem_port();
      logic [31:0] w;
      logic [31:0] off;
      begin_test();
      for (int i = 0; i < 256; i++) begin
         rand_bits(32, w);
         bus_write(12'h800 + 12'(i), w);
      end
      repeat (16) begin
         rand_bits(8, off);
         rand_bits(32, w);
         bus_write({4'h8, off[7:0]}, w);
      end
      check_range(8'h00, 256);
      end_test("memory bus port");
   endtask

   task automatic test_stream_runs();
      logic [31:0] c;
      begin_test();
      run_engine(0, 8'h10, 8'h60, 24, 32'hdead_beef, 12'h100);
      check_range(8'h60, 24);
      // source wraps past offset 0xff
      rand_bits(32, c);
      run_engine(1, 8'hf0, 8'h30, 40, c, 12'h100);
      check_range(8'h30, 40);
      rand_bits(32, c);
      run_engine(1, 8'h05, 8'ha0, 1, c, 12'h100);
      check_range(8'ha0, 1);
      end_test("copy and add constant");
   endtask

   task automatic test_accum();
      logic [31:0] c;
      begin_test();
      rand_bits(32, c);
      run_engine(2, 8'h80, 8'hc1, 32, c, 12'h100);
      check_range(8'hc0, 3);
      end_test("accumulate");
   endtask

   task automatic test_edges();
      int pulses;
      int n;
      int done_at;
      begin_test();
      run_engine(1, 8'h00, 8'hd0, 0, 32'h1234_5678, 12'h100);
      check_range(8'hd0, 4);
      run_engine(0, 8'h40, 8'he0, 3, 32'h0, 12'h000);
      check_range(8'he0, 3);
      configure(0, 8'h20, 8'hb0, 40, 32'h0);
      bus_write(12'h100, 32'h1);
      wait_busy_rise();
      // lands in the middle of the run
      bus_write(12'h100, 32'h1);
      pulses = 0;
      done_at = 0;
      // one negedge since busy rose went by during the write
      n = 1;
      repeat (80) begin
         @(negedge clk);
         n++;
         if (done) begin
            pulses++;
            done_at = n;
         end
      end
      check_value("done pulses", pulses, 1);
      check_value("done latency", done_at, 40 + 2);
      check_value("busy", busy, 0);
      apply_run(0, 8'h20, 8'hb0, 40, 32'h0);
      check_range(8'hb0, 40);
      end_test("edge cases");
   endtask

   initial begin
      clk = 1'b0;
      rst = 1'b1;
      ctr_req = 1'b0;
      ctr_rnw = 1'b1;
      ctr_addr = '0;
      data_to_wr = '0;
      lfsr = 32'hb1c9_f06f;
      cycles = 0;
      errors = 0;
      errors_at_start = 0;
      tests_run = 0;
      tests_failed = 0;
      ref_scratch = '0;
      repeat (5) @(posedge clk);
      rst <= 1'b0;
      test_reset();
      test_scratch();
      test_mem_port();
      test_stream_runs();
      test_accum();
      test_edges();
      $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed,
               errors);
      if (errors == 0) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: tb.f
logic/bus_map_pkg.sv
logic/engine_pkg.sv
logic/addr_decoder.sv
logic/conf_regs.sv
logic/eng_mem.sv
logic/run_counter.sv
logic/eng_ctrl.sv
logic/eng_datapath.sv
logic/engine_sys.sv
verification/tb_engine_sys.sv
